// ==== adc_consts.svh ====
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

// datapath widths
`define ADC_DATA_W           12
`define ADC_BYTECNT_W        7
`define ADC_FREQ_W           32

// register map
`define ADC_ADDR_GAIN        8'h00
`define ADC_ADDR_SETTINGS    8'h01
`define ADC_ADDR_STATUS      8'h02
`define ADC_ADDR_ARM         8'h03
`define ADC_ADDR_TRIG_LEVEL  8'h04
`define ADC_ADDR_EXTCLK_FREQ 8'h05
`define ADC_ADDR_EXTCLK_LIMIT 8'h06

// settings register fields
`define ADC_SET_LED_LSB      0
`define ADC_SET_LED_W        2
`define ADC_SET_SRC_BIT      2    // 1 = adc input, 0 = test counter
`define ADC_SET_MONDIS_BIT   3

// status register fields
`define ADC_STAT_ARMED_BIT   0
`define ADC_STAT_CHANGE_BIT  1
`define ADC_STAT_PLL_BIT     2

// led select codes, anything else turns both leds off
`define ADC_LED_SEL_STATUS    2'd0
`define ADC_LED_SEL_HEARTBEAT 2'd1

`endif

// ==== adc_pkg.sv ====
`include "adc_consts.svh"

package adc_pkg;

   // register bus from the host side
   typedef struct packed {
      logic [7:0]                addr;
      logic [`ADC_BYTECNT_W-1:0] bytecnt;  // byte index within a multi-byte register
      logic [7:0]                datai;
      logic                      read;
      logic                      write;
   } reg_bus_t;

   // register fields that the datapath blocks consume
   typedef struct packed {
      logic [`ADC_SET_LED_W-1:0] led_sel;
      logic                      src_adc;     // 0 selects the test counter
      logic                      mon_disable;
      logic [`ADC_DATA_W-1:0]    trig_level;
      logic [`ADC_FREQ_W-1:0]    extclk_limit;
   } ctrl_regs_t;

   // frequency monitor results
   typedef struct packed {
      logic [`ADC_FREQ_W-1:0]    extclk_freq;
      logic                      extclk_change;  // sticky until monitor disable
   } mon_status_t;

endpackage

// ==== adc_control_regs.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_control_regs (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  adc_pkg::reg_bus_t    reg_bus_i,
   input  adc_pkg::mon_status_t mon_i,
   input  logic                 armed_i,
   input  logic                 pll_status_i,
   output logic [7:0]           reg_datao_o,
   output adc_pkg::ctrl_regs_t  ctrl_o,
   output logic                 arm_stb_o,
   output logic                 amp_gain_o
);
   import adc_pkg::*;

   logic [7:0]             gain_r;
   logic [7:0]             settings_r;
   logic [`ADC_DATA_W-1:0] trig_level_r;
   logic [`ADC_FREQ_W-1:0] extclk_limit_r;
   logic [7:0]             status_byte;
   logic [8:0]             gain_acc;   // bit 8 is the carry out

   // pick byte n of a 32-bit word, lsb first, zero past the top
   function automatic logic [7:0] byte_sel(input logic [31:0]               word,
                                           input logic [`ADC_BYTECNT_W-1:0] n);
      logic [7:0] b;
      b = 8'h00;
      if (n < 'd4)
         b = word[n[1:0]*8 +: 8];
      return b;
   endfunction

   // register writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_r         <= '0;
         settings_r     <= '0;
         trig_level_r   <= '0;
         extclk_limit_r <= '0;
         arm_stb_o      <= 1'b0;
      end else begin
         arm_stb_o <= 1'b0;
         if (reg_bus_i.write) begin
            case (reg_bus_i.addr)
               `ADC_ADDR_GAIN:     gain_r <= reg_bus_i.datai;
               `ADC_ADDR_SETTINGS: settings_r <= reg_bus_i.datai;
               `ADC_ADDR_ARM:      arm_stb_o <= reg_bus_i.datai[0];  // one cycle only
               `ADC_ADDR_TRIG_LEVEL: begin
                  if (reg_bus_i.bytecnt == 'd0)
                     trig_level_r[7:0] <= reg_bus_i.datai;
                  else if (reg_bus_i.bytecnt == 'd1)
                     trig_level_r[`ADC_DATA_W-1:8] <= reg_bus_i.datai[`ADC_DATA_W-9:0];
               end
               `ADC_ADDR_EXTCLK_LIMIT: begin
                  if (reg_bus_i.bytecnt < 'd4)
                     extclk_limit_r[reg_bus_i.bytecnt[1:0]*8 +: 8] <= reg_bus_i.datai;
               end
               default: ;
            endcase
         end
      end
   end

   // status byte layout
   always_comb begin
      status_byte                       = 8'h00;
      status_byte[`ADC_STAT_ARMED_BIT]  = armed_i;
      status_byte[`ADC_STAT_CHANGE_BIT] = mon_i.extclk_change;
      status_byte[`ADC_STAT_PLL_BIT]    = pll_status_i;
   end

   // readback mux, zero whenever read is low
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_bus_i.read) begin
         case (reg_bus_i.addr)
            `ADC_ADDR_GAIN:        reg_datao_o = gain_r;
            `ADC_ADDR_SETTINGS:    reg_datao_o = settings_r;
            `ADC_ADDR_STATUS:      reg_datao_o = status_byte;
            `ADC_ADDR_TRIG_LEVEL:
               reg_datao_o = byte_sel({20'h0, trig_level_r}, reg_bus_i.bytecnt);
            `ADC_ADDR_EXTCLK_FREQ:
               reg_datao_o = byte_sel(mon_i.extclk_freq, reg_bus_i.bytecnt);
            `ADC_ADDR_EXTCLK_LIMIT:
               reg_datao_o = byte_sel(extclk_limit_r, reg_bus_i.bytecnt);
            default:               reg_datao_o = 8'h00;
         endcase
      end
   end

   // fields out to the peers
   always_comb begin
      ctrl_o.led_sel      = settings_r[`ADC_SET_LED_LSB +: `ADC_SET_LED_W];
      ctrl_o.src_adc      = settings_r[`ADC_SET_SRC_BIT];
      ctrl_o.mon_disable  = settings_r[`ADC_SET_MONDIS_BIT];
      ctrl_o.trig_level   = trig_level_r;
      ctrl_o.extclk_limit = extclk_limit_r;
   end

   // pulse-density gain output
   // carry fires gain times per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset)
         gain_acc <= '0;
      else
         gain_acc <= {1'b0, gain_acc[7:0]} + {1'b0, gain_r};
   end

   assign amp_gain_o = gain_acc[8];

endmodule

// ==== adc_sample_path.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_sample_path (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic [`ADC_DATA_W-1:0] adc_data_i,
   input  adc_pkg::ctrl_regs_t    ctrl_i,
   input  logic                   arm_stb_i,
   output logic                   armed_o,
   output logic                   trigger_adc_o
);
   import adc_pkg::*;

   logic [`ADC_DATA_W-1:0] adc_q;      // input capture
   logic [`ADC_DATA_W-1:0] data_pre;   // after source select
   logic [`ADC_DATA_W-1:0] sample_r;
   logic [`ADC_DATA_W-1:0] test_cnt;
   logic                   level_hit;

   // free-running test pattern
   always_ff @(posedge clk_usb) begin
      if (reset)
         test_cnt <= '0;
      else
         test_cnt <= test_cnt + 1'b1;
   end

   always_ff @(posedge clk_usb) begin
      adc_q    <= adc_data_i;
      data_pre <= ctrl_i.src_adc ? adc_q : test_cnt;
      sample_r <= data_pre;
   end

   // level msb picks the direction
   // set means above the level, clear means below it
   always_comb begin
      if (ctrl_i.trig_level[`ADC_DATA_W-1])
         level_hit = sample_r > ctrl_i.trig_level;
      else
         level_hit = sample_r < ctrl_i.trig_level;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_o       <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         trigger_adc_o <= armed_o & level_hit & ~trigger_adc_o;  // single pulse per arm
         if (trigger_adc_o)
            armed_o <= 1'b0;
         else if (arm_stb_i)
            armed_o <= 1'b1;
      end
   end

endmodule

// ==== clock_monitor.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module clock_monitor #(
   parameter int GATE_LOG2 = 22
) (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic                 ext_tick_i,
   input  adc_pkg::ctrl_regs_t  ctrl_i,
   output logic                 gate_stb_o,
   output adc_pkg::mon_status_t mon_o
);
   import adc_pkg::*;

   logic [GATE_LOG2:0]     gate_timer;
   logic                   timer_top_q;
   logic [`ADC_FREQ_W-1:0] tick_cnt;
   logic [`ADC_FREQ_W-1:0] freq_r;
   logic [`ADC_FREQ_W-1:0] freq_new;
   logic [`ADC_FREQ_W-1:0] freq_diff;
   logic                   change_r;

   // gate window generator
   // the top bit toggles once per 2^GATE_LOG2 cycles, either edge ends a window
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gate_timer  <= '0;
         timer_top_q <= 1'b0;
         gate_stb_o  <= 1'b0;
      end else begin
         gate_timer  <= gate_timer + 1'b1;
         timer_top_q <= gate_timer[GATE_LOG2];
         gate_stb_o  <= gate_timer[GATE_LOG2] ^ timer_top_q;
      end
   end

   // count for this window, tick on the gate cycle included
   assign freq_new  = tick_cnt + {{(`ADC_FREQ_W-1){1'b0}}, ext_tick_i};
   assign freq_diff = (freq_new >= freq_r) ? (freq_new - freq_r) : (freq_r - freq_new);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         tick_cnt <= '0;
         freq_r   <= '0;
      end else if (gate_stb_o) begin
         freq_r   <= freq_new;
         tick_cnt <= '0;
      end else begin
         tick_cnt <= freq_new;
      end
   end

   // sticky change flag, held clear while monitoring is off
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_r <= 1'b0;
      else if (ctrl_i.mon_disable)
         change_r <= 1'b0;
      else if (gate_stb_o && (freq_r != '0) && (freq_diff > ctrl_i.extclk_limit))
         change_r <= 1'b1;
   end

   always_comb begin
      mon_o.extclk_freq   = freq_r;
      mon_o.extclk_change = change_r;
   end

endmodule

// ==== led_status.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module led_status #(
   parameter int GATE_LOG2 = 22
) (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  adc_pkg::ctrl_regs_t  ctrl_i,
   input  logic                 armed_i,
   input  adc_pkg::mon_status_t mon_i,
   output logic                 led_armed_o,
   output logic                 led_capture_o
);
   import adc_pkg::*;

   logic [GATE_LOG2+3:0] hb_cnt;
   logic                 flash_r;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         hb_cnt  <= '0;
         flash_r <= 1'b0;
      end else begin
         hb_cnt <= hb_cnt + 1'b1;
         if (hb_cnt[GATE_LOG2+3])
            flash_r <= ~hb_cnt[GATE_LOG2+1];  // blink during upper half of the count
      end
   end

   // clock change alarm overrides the select
   always_comb begin
      if (mon_i.extclk_change) begin
         led_armed_o   = flash_r;
         led_capture_o = flash_r;
      end else if (ctrl_i.led_sel == `ADC_LED_SEL_STATUS) begin
         led_armed_o   = armed_i;
         led_capture_o = mon_i.extclk_change;
      end else if (ctrl_i.led_sel == `ADC_LED_SEL_HEARTBEAT) begin
         led_armed_o   = hb_cnt[GATE_LOG2+2];
         led_capture_o = hb_cnt[GATE_LOG2+1];
      end else begin
         led_armed_o   = 1'b0;
         led_capture_o = 1'b0;
      end
   end

endmodule

// ==== adc_interface.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_interface #(
   parameter int GATE_LOG2 = 22
) (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic [`ADC_DATA_W-1:0] adc_data_i,
   input  logic                   ext_tick_i,    // target clock, already synchronized
   input  logic                   pll_status_i,
   input  adc_pkg::reg_bus_t      reg_bus_i,
   output logic [7:0]             reg_datao_o,
   output logic                   trigger_adc_o,
   output logic                   freq_measure_o,
   output logic                   amp_gain_o,
   output logic                   led_armed_o,
   output logic                   led_capture_o
);
   import adc_pkg::*;

   ctrl_regs_t  ctrl;
   mon_status_t mon;
   logic        arm_stb;
   logic        armed;

   adc_control_regs u_regs (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .reg_bus_i    (reg_bus_i),
      .mon_i        (mon),
      .armed_i      (armed),
      .pll_status_i (pll_status_i),
      .reg_datao_o  (reg_datao_o),
      .ctrl_o       (ctrl),
      .arm_stb_o    (arm_stb),
      .amp_gain_o   (amp_gain_o)
   );

   adc_sample_path u_sample (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .adc_data_i    (adc_data_i),
      .ctrl_i        (ctrl),
      .arm_stb_i     (arm_stb),
      .armed_o       (armed),
      .trigger_adc_o (trigger_adc_o)
   );

   clock_monitor #(
      .GATE_LOG2 (GATE_LOG2)
   ) u_clkmon (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .ext_tick_i (ext_tick_i),
      .ctrl_i     (ctrl),
      .gate_stb_o (freq_measure_o),  // gate strobe goes straight out
      .mon_o      (mon)
   );

   led_status #(
      .GATE_LOG2 (GATE_LOG2)
   ) u_leds (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .ctrl_i        (ctrl),
      .armed_i       (armed),
      .mon_i         (mon),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o)
   );

endmodule

// ==== tb_adc_interface.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module tb_adc_interface;
   import adc_pkg::*;

   logic                   clk_usb = 1'b0;
   logic                   reset;
   logic [`ADC_DATA_W-1:0] adc_data_i;
   logic                   ext_tick_i;
   logic                   pll_status_i;
   reg_bus_t               reg_bus_i;
   logic [7:0]             reg_datao_o;
   logic                   trigger_adc_o;
   logic                   freq_measure_o;
   logic                   amp_gain_o;
   logic                   led_armed_o;
   logic                   led_capture_o;

   int errors = 0;
   int checks = 0;
   int tick_period = 0;  // 0 stops the target clock
   int tick_phase = 0;

   adc_interface #(.GATE_LOG2(6)) u_dut (.*);

   always #10 clk_usb = ~clk_usb;

   // one target clock tick every tick_period cycles
   always @(posedge clk_usb) begin
      #2;
      if (tick_period == 0) begin
         ext_tick_i = 1'b0;
         tick_phase = 0;
      end else begin
         ext_tick_i = (tick_phase == 0);
         tick_phase = (tick_phase + 1) % tick_period;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("%0t: %s", $time, what);
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [6:0] bcnt,
                            input logic [7:0] data);
      @(posedge clk_usb);
      #2;
      reg_bus_i.addr    = addr;
      reg_bus_i.bytecnt = bcnt;
      reg_bus_i.datai   = data;
      reg_bus_i.write   = 1'b1;
      @(posedge clk_usb);
      #2;
      reg_bus_i.write = 1'b0;
   endtask

   task automatic reg_read(input logic [7:0] addr, input logic [6:0] bcnt,
                           output logic [7:0] data);
      @(posedge clk_usb);
      #2;
      reg_bus_i.addr    = addr;
      reg_bus_i.bytecnt = bcnt;
      reg_bus_i.read    = 1'b1;
      @(negedge clk_usb);
      data = reg_datao_o;  // combinational readback settles by mid-cycle
      @(posedge clk_usb);
      #2;
      reg_bus_i.read = 1'b0;
   endtask

   // multi-byte access with byte 0 as the lsb
   task automatic write_word(input logic [7:0] addr, input int nbytes, input logic [31:0] value);
      for (int i = 0; i < nbytes; i++)
         reg_write(addr, 7'(i), value[i*8 +: 8]);
   endtask

   task automatic read_word(input logic [7:0] addr, input int nbytes, output logic [31:0] value);
      logic [7:0] b;
      value = '0;
      for (int i = 0; i < nbytes; i++) begin
         reg_read(addr, 7'(i), b);
         value[i*8 +: 8] = b;
      end
   endtask

   task automatic wait_trigger(input int limit, output bit found);
      found = 1'b0;
      for (int n = 0; n < limit && !found; n++) begin
         @(negedge clk_usb);
         found = trigger_adc_o;
      end
   endtask

   task automatic count_triggers(input int cycles, output int pulses);
      pulses = 0;
      repeat (cycles) begin
         @(negedge clk_usb);
         pulses += trigger_adc_o;
      end
   endtask

   task automatic wait_gates(input int count);
      int n;
      for (int g = 0; g < count; g++) begin
         n = 0;
         do begin
            @(negedge clk_usb);
            n++;
         end while (!freq_measure_o && n < 200);
         assert (freq_measure_o)
            else note_failure("no freq_measure_o pulse within 200 cycles");
         if (freq_measure_o && g > 0)
            check_val("freq_measure_o period", n, 64);  // 2^6 cycles per gate
      end
   endtask

   task automatic register_access();
      logic [31:0] v;
      logic [31:0] got;
      v = {24'h0, 8'($urandom)};
      write_word(`ADC_ADDR_GAIN, 1, v);
      read_word(`ADC_ADDR_GAIN, 1, got);
      check_val("gain", got, v);
      v = {20'h0, 12'($urandom)};
      write_word(`ADC_ADDR_TRIG_LEVEL, 2, v);
      read_word(`ADC_ADDR_TRIG_LEVEL, 2, got);
      check_val("trig_level", got, v);
      v = $urandom;
      write_word(`ADC_ADDR_EXTCLK_LIMIT, 4, v);
      read_word(`ADC_ADDR_EXTCLK_LIMIT, 4, got);
      check_val("extclk_limit", got, v);
      read_word(`ADC_ADDR_STATUS, 1, got);
      check_val("status armed/change", got[1:0], 0);
      @(posedge clk_usb);
      #2;
      pll_status_i = 1'b1;
      read_word(`ADC_ADDR_STATUS, 1, got);
      check_val("status pll", got[2], 1);
      @(posedge clk_usb);
      #2;
      pll_status_i = 1'b0;
      read_word(`ADC_ADDR_STATUS, 1, got);
      check_val("status pll", got[2], 0);
   endtask

   task automatic gain_duty();
      logic [7:0] g;
      int highs;
      g = 8'($urandom);
      highs = 0;
      reg_write(`ADC_ADDR_GAIN, 0, g);
      repeat (256) @(posedge clk_usb);
      repeat (256) begin
         @(negedge clk_usb);
         highs += amp_gain_o;
      end
      check_val("amp_gain_o high cycles", highs, g);
   endtask

   // arm at idle_val and then step the input to hit_val
   task automatic level_trigger_case(input logic [11:0] level, input logic [11:0] idle_val,
                                     input logic [11:0] hit_val);
      logic [31:0] s;
      bit found;
      int pulses;
      write_word(`ADC_ADDR_TRIG_LEVEL, 2, {20'h0, level});
      @(posedge clk_usb);
      #2;
      adc_data_i = idle_val;
      repeat (4) @(posedge clk_usb);  // flush the sample pipeline
      reg_write(`ADC_ADDR_ARM, 0, 8'h01);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status armed", s[0], 1);
      @(negedge clk_usb);
      check_val("led_armed_o", led_armed_o, 1);
      @(posedge clk_usb);
      #2;
      adc_data_i = hit_val;
      wait_trigger(20, found);
      assert (found)
         else note_failure("no trigger_adc_o pulse after the level crossing");
      count_triggers(40, pulses);
      check_val("extra trigger_adc_o pulses", pulses, 0);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status armed", s[0], 0);
   endtask

   task automatic counter_source_trigger();
      logic [31:0] s;
      bit found;
      int pulses;
      int tail;
      reg_write(`ADC_ADDR_SETTINGS, 0, 8'h00);
      write_word(`ADC_ADDR_TRIG_LEVEL, 2, 32'h800);
      reg_write(`ADC_ADDR_ARM, 0, 8'h01);
      wait_trigger(4200, found);
      assert (found)
         else note_failure("test counter never crossed level 0x800 within 4200 cycles");
      count_triggers(20, pulses);
      check_val("extra trigger_adc_o pulses", pulses, 0);
      // level 0 with bit 11 clear asks for a sample below zero
      reg_write(`ADC_ADDR_SETTINGS, 0, 8'h04);
      write_word(`ADC_ADDR_TRIG_LEVEL, 2, 32'h000);
      reg_write(`ADC_ADDR_ARM, 0, 8'h01);
      pulses = 0;
      repeat (10) begin
         @(posedge clk_usb);
         #2;
         adc_data_i = 12'($urandom);
         @(negedge clk_usb);
         pulses += trigger_adc_o;
      end
      count_triggers(4, tail);  // pipeline tail
      check_val("trigger_adc_o pulses at level 0", pulses + tail, 0);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status armed", s[0], 1);
   endtask

   task automatic frequency_measure();
      logic [31:0] f;
      write_word(`ADC_ADDR_EXTCLK_LIMIT, 4, 32'd1000);
      tick_period = 4;
      wait_gates(2);
      read_word(`ADC_ADDR_EXTCLK_FREQ, 4, f);
      check_val("extclk_freq", f, 16);  // 64 cycle gate / 4
      tick_period = 2;
      wait_gates(2);
      read_word(`ADC_ADDR_EXTCLK_FREQ, 4, f);
      check_val("extclk_freq", f, 32);
   endtask

   task automatic change_detect();
      logic [31:0] s;
      int mismatches;
      int highs;
      tick_period = 4;
      wait_gates(3);
      write_word(`ADC_ADDR_EXTCLK_LIMIT, 4, 32'd8);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status change", s[1], 0);
      tick_period = 2;  // 16 to 32 exceeds 8
      wait_gates(2);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status change", s[1], 1);
      mismatches = 0;
      highs = 0;
      repeat (1100) begin  // longer than one full heartbeat period
         @(negedge clk_usb);
         if (led_armed_o !== led_capture_o)
            mismatches++;
         highs += led_armed_o;
      end
      check_val("led pair mismatches while flashing", mismatches, 0);
      assert (highs > 0 && highs < 1100)
         else note_failure("leds did not flash while extclk change was set");
      reg_write(`ADC_ADDR_SETTINGS, 0, 8'h0C);  // monitor disable
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status change", s[1], 0);
      reg_write(`ADC_ADDR_SETTINGS, 0, 8'h04);
      write_word(`ADC_ADDR_EXTCLK_LIMIT, 4, 32'd20);
      tick_period = 4;
      wait_gates(3);
      tick_period = 2;
      wait_gates(3);
      read_word(`ADC_ADDR_STATUS, 1, s);
      check_val("status change", s[1], 0);
   endtask

   initial begin
      void'($urandom(32'h6778_c3d5));
      reset        = 1'b1;
      adc_data_i   = '0;
      ext_tick_i   = 1'b0;
      pll_status_i = 1'b0;
      reg_bus_i    = '0;
      repeat (5) @(posedge clk_usb);
      #2;
      reset = 1'b0;
      register_access();
      gain_duty();
      reg_write(`ADC_ADDR_SETTINGS, 0, 8'h04);  // adc source, status leds
      level_trigger_case(12'h900, 12'h100, 12'hA00);
      level_trigger_case(12'h300, 12'hA00, 12'h100);
      counter_source_trigger();
      frequency_measure();
      change_detect();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
adc_pkg.sv
adc_control_regs.sv
adc_sample_path.sv
clock_monitor.sv
led_status.sv
adc_interface.sv
tb_adc_interface.sv

// ==== Bender.yml ====
package:
  name: adc_interface

sources:
  - include_dirs:
      - .
    files:
      - adc_pkg.sv
      - adc_control_regs.sv
      - adc_sample_path.sv
      - clock_monitor.sv
      - led_status.sv
      - adc_interface.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_adc_interface.sv
